//--- filelist.f
+incdir+tb
hdl/simmem_pkg.sv
hdl/msg_ram_if.sv
hdl/slot_allocator.sv
hdl/id_queue_table.sv
hdl/message_ram_arbiter.sv
hdl/release_scheduler.sv
hdl/simmem_resp_bank.sv
tb/tb_simmem_resp_bank.sv

//--- Bender.yml
package:
  name: simmem_resp_bank

sources:
  # Design, in compile order
  - hdl/simmem_pkg.sv
  - hdl/msg_ram_if.sv
  - hdl/slot_allocator.sv
  - hdl/id_queue_table.sv
  - hdl/message_ram_arbiter.sv
  - hdl/release_scheduler.sv
  - hdl/simmem_resp_bank.sv
  # Testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_simmem_resp_bank.sv

//--- tb/simmem_ref_model.svh
// Reference model with slot occupancy, per-identifier slot FIFOs and expected-result functions
`ifndef SIMMEM_REF_MODEL_SVH
`define SIMMEM_REF_MODEL_SVH

logic                 occupied    [Capacity];
logic [AddrWidth-1:0] fifo_slot   [NumIds][Capacity];
int                   fifo_head   [NumIds];
int                   fifo_len    [NumIds];
// Stored entries sit at the front of each FIFO with unfilled ones behind them
int                   fifo_filled [NumIds];
logic [MsgWidth-1:0]  mem_copy    [Capacity];
// Output register contents
logic                 exp_valid;
logic [AddrWidth-1:0] exp_slot;
logic [MsgWidth-1:0]  exp_data;

function automatic void clear_model();
  for (int s = 0; s < Capacity; s++) begin
    occupied[s] = 1'b0;
  end
  for (int id = 0; id < NumIds; id++) begin
    fifo_head[id]   = 0;
    fifo_len[id]    = 0;
    fifo_filled[id] = 0;
  end
  exp_valid = 1'b0;
  exp_slot  = '0;
  exp_data  = '0;
endfunction

function automatic logic any_slot_free();
  logic found;
  found = 1'b0;
  for (int s = 0; s < Capacity; s++) begin
    if (!occupied[s]) begin
      found = 1'b1;
    end
  end
  return found;
endfunction

// First free slot counting upward from slot 0
function automatic logic [AddrWidth-1:0] lowest_free_slot();
  logic [AddrWidth-1:0] pick;
  logic                 found;
  pick  = '0;
  found = 1'b0;
  for (int s = 0; s < Capacity; s++) begin
    if (!found && !occupied[s]) begin
      pick  = AddrWidth'(s);
      found = 1'b1;
    end
  end
  return pick;
endfunction

function automatic int unfilled_count(input int id);
  return fifo_len[id] - fifo_filled[id];
endfunction

// Lowest identifier whose oldest stored message has its release bit set, or -1
function automatic int pick_release_id(input logic [Capacity-1:0] en);
  int pick;
  pick = -1;
  for (int id = NumIds - 1; id >= 0; id--) begin
    if (fifo_filled[id] > 0 && en[fifo_slot[id][fifo_head[id]]]) begin
      pick = id;
    end
  end
  return pick;
endfunction

function automatic void reserve_slot(input int id, input logic [AddrWidth-1:0] slot);
  fifo_slot[id][(fifo_head[id] + fifo_len[id]) % Capacity] = slot;
  fifo_len[id]++;
  occupied[slot] = 1'b1;
endfunction

function automatic void store_word(input int id, input logic [MsgWidth-1:0] word);
  mem_copy[fifo_slot[id][(fifo_head[id] + fifo_filled[id]) % Capacity]] = word;
  fifo_filled[id]++;
endfunction

function automatic void issue_release(input int id);
  exp_slot      = fifo_slot[id][fifo_head[id]];
  exp_data      = mem_copy[exp_slot];
  exp_valid     = 1'b1;
  fifo_head[id] = (fifo_head[id] + 1) % Capacity;
  fifo_len[id]--;
  fifo_filled[id]--;
endfunction

function automatic void retire_output();
  occupied[exp_slot] = 1'b0;
  exp_valid          = 1'b0;
endfunction

function automatic logic bank_empty();
  logic busy;
  busy = exp_valid;
  for (int s = 0; s < Capacity; s++) begin
    busy = busy | occupied[s];
  end
  return !busy;
endfunction

`endif

//--- tb/tb_simmem_resp_bank.sv
// Testbench for the response bank: clock, reset, directed and random tests, output compare
`timescale 1ns/1ps
`default_nettype none

module tb_simmem_resp_bank;
  import simmem_pkg::*;

  localparam int ClkPeriod      = 40;
  localparam int RandCycles     = 600;
  localparam int WaitLimit      = 200;
  // Rough length of reset, the directed tests, the random run and its drain
  localparam int DirectedCycles = 200;
  localparam int DrainCycles    = 100;
  localparam int StimCycles     = DirectedCycles + RandCycles + DrainCycles;
  localparam int TimeoutCycles  = 4 * StimCycles;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic [NumIds-1:0]    rsv_id_onehot;
  logic                 rsv_ready;
  logic                 rsv_valid;
  logic [AddrWidth-1:0] rsv_addr;
  logic [MsgWidth-1:0]  data_in;
  logic                 in_valid;
  logic                 in_ready;
  logic [Capacity-1:0]  release_en;
  logic                 out_ready;
  logic                 out_valid;
  logic [MsgWidth-1:0]  data_out;
  logic [Capacity-1:0]  released_onehot;

  integer               seed;
  int                   cycle_cnt;
  int                   err_cnt;
  int                   check_cnt;
  int                   release_cnt;
  int                   test_num;
  int                   test_errs;
  int                   failed_tests;
  logic [AddrWidth-1:0] release_log [$];

  `include "simmem_ref_model.svh"

  simmem_resp_bank u_dut (
    .clk_i                           (clk),
    .rst_ni                          (rst_n),
    .reservation_request_id_onehot_i (rsv_id_onehot),
    .reservation_request_ready_i     (rsv_ready),
    .reservation_request_valid_o     (rsv_valid),
    .new_reserved_address_o          (rsv_addr),
    .data_i                          (data_in),
    .in_valid_i                      (in_valid),
    .in_ready_o                      (in_ready),
    .release_en_i                    (release_en),
    .out_ready_i                     (out_ready),
    .out_valid_o                     (out_valid),
    .data_o                          (data_out),
    .address_released_onehot_o       (released_onehot)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_equal(input string name, input logic [MsgWidth-1:0] got,
                             input logic [MsgWidth-1:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  function automatic logic [MsgWidth-1:0] make_word(input int id);
    logic [MsgWidth-1:0] rnd;
    rnd = $random(seed);
    return {rnd[MsgWidth-1:IdWidth], IdWidth'(id)};
  endfunction

  // All stimulus tasks start and end on a falling edge
  task automatic reserve_for(input int id);
    rsv_ready     = 1'b1;
    rsv_id_onehot = NumIds'(1) << id;
    @(posedge clk);
    @(negedge clk);
    rsv_ready = 1'b0;
  endtask

  task automatic send_word(input int id);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    in_valid = 1'b1;
    data_in  = make_word(id);
    while (!accepted && waited < WaitLimit) begin
      @(posedge clk);
      accepted = in_ready;
      waited++;
      @(negedge clk);
    end
    in_valid = 1'b0;
    if (!accepted) begin
      $display("Error: a word for identifier %0d was never accepted", id);
      err_cnt++;
    end
  endtask

  task automatic wait_releases(input int target);
    int waited;
    waited = 0;
    while (release_cnt < target && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (release_cnt < target) begin
      $display("Error: only %0d of %0d expected releases arrived", release_cnt, target);
      err_cnt++;
    end
  endtask

  // Fill every open reservation and release everything
  task automatic drain_bank();
    int waited;
    int fill_id;
    waited     = 0;
    rsv_ready  = 1'b0;
    release_en = '1;
    out_ready  = 1'b1;
    while (!bank_empty() && waited < DrainCycles) begin
      fill_id = -1;
      for (int id = NumIds - 1; id >= 0; id--) begin
        if (unfilled_count(id) > 0) begin
          fill_id = id;
        end
      end
      in_valid = fill_id >= 0;
      data_in  = make_word(fill_id);
      @(negedge clk);
      waited++;
    end
    in_valid = 1'b0;
    if (!bank_empty()) begin
      $display("Error: the bank still held messages after the drain");
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (err_cnt != test_errs) begin
      failed_tests++;
    end
    $display("Test %0d %s: %0d errors", test_num, name, err_cnt - test_errs);
    test_errs = err_cnt;
  endtask

  //////////////////////////////
  // Compare against the model
  //////////////////////////////

  always @(posedge clk) begin : compare_outputs
    logic                 free_now;
    logic [AddrWidth-1:0] free_addr;
    logic                 out_hs;
    logic                 read_req;
    logic                 store_ok;
    int                   rel_id;
    int                   in_id;
    int                   rsv_id;
    if (rst_n) begin
      free_now  = any_slot_free();
      free_addr = lowest_free_slot();
      check_equal("reservation_request_valid_o", rsv_valid, free_now);
      if (free_now) begin
        check_equal("new_reserved_address_o", rsv_addr, free_addr);
      end
      out_hs = exp_valid && out_ready;
      check_equal("out_valid_o", out_valid, exp_valid);
      if (out_hs) begin
        check_equal("data_o", data_out, exp_data);
        check_equal("address_released_onehot_o", released_onehot, Capacity'(1) << exp_slot);
      end else begin
        check_equal("address_released_onehot_o", released_onehot, '0);
      end
      // A release read takes the memory ahead of any store
      rel_id   = pick_release_id(release_en);
      read_req = (!exp_valid || out_ready) && rel_id >= 0;
      in_id    = int'(data_in[IdWidth-1:0]);
      store_ok = in_valid && unfilled_count(in_id) > 0 && !read_req;
      check_equal("in_ready_o", in_ready, store_ok);

      if (out_hs) begin
        release_log.push_back(exp_slot);
        release_cnt++;
        retire_output();
      end
      if (read_req) begin
        issue_release(rel_id);
      end
      if (store_ok) begin
        store_word(in_id, data_in);
      end
      if (free_now && rsv_ready) begin
        rsv_id = 0;
        for (int b = 0; b < NumIds; b++) begin
          if (rsv_id_onehot[b]) begin
            rsv_id = b;
          end
        end
        reserve_slot(rsv_id, free_addr);
      end
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin : run_tests
    int          base;
    logic [31:0] rnd;
    logic [31:0] rnd_en;
    seed          = 32'hce9a_b349;
    cycle_cnt     = 0;
    err_cnt       = 0;
    check_cnt     = 0;
    release_cnt   = 0;
    test_num      = 0;
    test_errs     = 0;
    failed_tests  = 0;
    rst_n         = 1'b0;
    rsv_id_onehot = '0;
    rsv_ready     = 1'b0;
    data_in       = '0;
    in_valid      = 1'b0;
    release_en    = '0;
    out_ready     = 1'b0;
    clear_model();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    @(posedge clk);
    check_equal("out_valid_o", out_valid, 1'b0);
    check_equal("in_ready_o", in_ready, 1'b0);
    check_equal("reservation_request_valid_o", rsv_valid, 1'b1);
    check_equal("new_reserved_address_o", rsv_addr, '0);
    @(negedge clk);
    finish_test("reset values");

    // Empty bank hands out slots in ascending order
    for (int i = 0; i < Capacity; i++) begin
      rsv_ready     = 1'b1;
      rsv_id_onehot = NumIds'(1) << (i % 3);
      @(posedge clk);
      check_equal("new_reserved_address_o", rsv_addr, i);
      @(negedge clk);
    end
    rsv_ready = 1'b0;
    @(posedge clk);
    check_equal("reservation_request_valid_o", rsv_valid, 1'b0);
    @(negedge clk);
    finish_test("in-order reservation");

    // Identifier 3 holds no reservation here
    in_valid = 1'b1;
    data_in  = make_word(3);
    @(posedge clk);
    check_equal("in_ready_o", in_ready, 1'b0);
    @(negedge clk);
    in_valid = 1'b0;
    for (int i = 0; i < Capacity; i++) begin
      send_word(i % 3);
    end
    release_en = '1;
    out_ready  = 1'b1;
    wait_releases(Capacity);
    finish_test("store without reservation");

    // Bank is empty again, so identifier 1 gets slots 0 to 3
    release_en = '0;
    for (int i = 0; i < 4; i++) begin
      reserve_for(1);
    end
    for (int i = 0; i < 4; i++) begin
      send_word(1);
    end
    base          = release_cnt;
    release_en[2] = 1'b1;
    repeat (4) @(negedge clk);
    check_equal("out_valid_o", out_valid, 1'b0);
    release_en[0] = 1'b1;
    wait_releases(base + 1);
    repeat (4) @(negedge clk);
    check_equal("release count", release_cnt, base + 1);
    release_en[1] = 1'b1;
    wait_releases(base + 3);
    release_en[3] = 1'b1;
    wait_releases(base + 4);
    for (int k = 0; k < 4; k++) begin
      check_equal("released slot", release_log[base + k], k);
    end
    finish_test("gated release in order");

    // Identifier 3 takes slot 0, identifier 0 takes slot 3
    release_en = '0;
    for (int id = NumIds - 1; id >= 0; id--) begin
      reserve_for(id);
    end
    for (int id = 0; id < NumIds; id++) begin
      send_word(id);
    end
    base       = release_cnt;
    release_en = '1;
    wait_releases(base + NumIds);
    for (int k = 0; k < NumIds; k++) begin
      check_equal("released slot", release_log[base + k], NumIds - 1 - k);
    end
    @(posedge clk);
    check_equal("new_reserved_address_o", rsv_addr, '0);
    @(negedge clk);
    finish_test("lowest identifier first");

    for (int c = 0; c < RandCycles; c++) begin
      rnd           = $random(seed);
      rnd_en        = $random(seed);
      rsv_ready     = rnd[1:0] == 2'b00;
      rsv_id_onehot = NumIds'(1) << rnd[3:2];
      in_valid      = rnd[4] | rnd[5];
      data_in       = make_word(rnd[7:6]);
      release_en    = rnd_en[Capacity-1:0];
      out_ready     = rnd[8] | rnd[9];
      @(negedge clk);
    end
    drain_bank();
    finish_test("random traffic");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_num, failed_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/simmem_resp_bank.sv
// Response bank top level wiring the allocator, queue table, memory and scheduler
`timescale 1ns/1ps
`default_nettype none

module simmem_resp_bank (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [simmem_pkg::NumIds-1:0]    reservation_request_id_onehot_i,
  input  logic                             reservation_request_ready_i,
  output logic                             reservation_request_valid_o,
  output logic [simmem_pkg::AddrWidth-1:0] new_reserved_address_o,
  input  logic [simmem_pkg::MsgWidth-1:0]  data_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  input  logic [simmem_pkg::Capacity-1:0]  release_en_i,
  input  logic                             out_ready_i,
  output logic                             out_valid_o,
  output logic [simmem_pkg::MsgWidth-1:0]  data_o,
  output logic [simmem_pkg::Capacity-1:0]  address_released_onehot_o
);
  import simmem_pkg::*;

  logic                             reserve;
  logic [NumIds-1:0]                stored;
  logic [NumIds-1:0][AddrWidth-1:0] out_ptr;
  logic                             issue;
  logic [NumIds-1:0]                issue_id_onehot;

  msg_ram_if store_if ();
  msg_ram_if read_if ();

  // Reservation handshake
  assign reserve = reservation_request_valid_o && reservation_request_ready_i;

  slot_allocator u_slot_allocator (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .alloc_i     (reserve),
    .free_mask_i (address_released_onehot_o),
    .free_addr_o (new_reserved_address_o),
    .any_free_o  (reservation_request_valid_o)
  );

  id_queue_table u_id_queue_table (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .reserve_id_onehot_i (reservation_request_id_onehot_i),
    .reserve_i           (reserve),
    .free_addr_i         (new_reserved_address_o),
    .data_i              (data_i),
    .in_valid_i          (in_valid_i),
    .in_ready_o          (in_ready_o),
    .store_if            (store_if.requester),
    .issue_i             (issue),
    .issue_id_onehot_i   (issue_id_onehot),
    .stored_o            (stored),
    .out_ptr_o           (out_ptr)
  );

  message_ram_arbiter u_message_ram_arbiter (
    .clk_i    (clk_i),
    .store_if (store_if.arbiter),
    .read_if  (read_if.arbiter)
  );

  release_scheduler u_release_scheduler (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .stored_i          (stored),
    .out_ptr_i         (out_ptr),
    .release_en_i      (release_en_i),
    .read_if           (read_if.requester),
    .issue_o           (issue),
    .issue_id_onehot_o (issue_id_onehot),
    .data_o            (data_o),
    .out_valid_o       (out_valid_o),
    .out_ready_i       (out_ready_i),
    .released_onehot_o (address_released_onehot_o)
  );

endmodule

`default_nettype wire

//--- hdl/release_scheduler.sv
// Release candidate selection, message read and output register
`timescale 1ns/1ps
`default_nettype none

module release_scheduler (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic [simmem_pkg::NumIds-1:0]                        stored_i,
  input  logic [simmem_pkg::NumIds-1:0][simmem_pkg::AddrWidth-1:0] out_ptr_i,
  input  logic [simmem_pkg::Capacity-1:0]                      release_en_i,
  msg_ram_if.requester                                         read_if,
  output logic                                                 issue_o,
  output logic [simmem_pkg::NumIds-1:0]                        issue_id_onehot_o,
  output logic [simmem_pkg::MsgWidth-1:0]                      data_o,
  output logic                                                 out_valid_o,
  input  logic                                                 out_ready_i,
  output logic [simmem_pkg::Capacity-1:0]                      released_onehot_o
);
  import simmem_pkg::*;

  logic [NumIds-1:0]    eligible;
  logic [NumIds-1:0]    pick_onehot;
  logic [AddrWidth-1:0] pick_addr;
  logic                 can_issue;
  logic                 out_valid_q;
  logic [AddrWidth-1:0] out_slot_q;

  //////////////////////////////
  // Candidate selection
  //////////////////////////////

  // Oldest stored message of each identifier, gated by its release bit
  for (genvar i = 0; i < NumIds; i++) begin : gen_cand
    assign eligible[i] = stored_i[i] && release_en_i[out_ptr_i[i]];
  end

  // Lowest set bit wins
  assign pick_onehot = eligible & (~eligible + NumIds'(1));

  always_comb begin
    pick_addr = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (pick_onehot[i]) begin
        pick_addr = pick_addr | out_ptr_i[i];
      end
    end
  end

  //////////////////////////////
  // Read issue
  //////////////////////////////

  // Register free or draining this cycle
  assign can_issue = !out_valid_q || out_ready_i;

  assign read_if.req   = can_issue && |eligible;
  assign read_if.we    = 1'b0;
  assign read_if.addr  = pick_addr;
  assign read_if.wdata = '0;

  assign issue_o           = read_if.req && read_if.gnt;
  assign issue_id_onehot_o = pick_onehot;

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (issue_o) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      out_slot_q <= pick_addr;
    end
  end

  // Read data holds until the next issue, so it stays stable while stalled
  assign out_valid_o = out_valid_q;
  assign data_o      = read_if.rdata;

  always_comb begin
    released_onehot_o = '0;
    if (out_valid_q && out_ready_i) begin
      released_onehot_o[out_slot_q] = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/message_ram_arbiter.sv
// Message storage behind a read-first fixed priority arbiter
`timescale 1ns/1ps
`default_nettype none

module message_ram_arbiter (
  input logic        clk_i,
  msg_ram_if.arbiter store_if,
  msg_ram_if.arbiter read_if
);
  import simmem_pkg::*;

  logic [MsgWidth-1:0]  mem_q [Capacity];
  logic [MsgWidth-1:0]  rdata_q;

  logic                 access;
  logic                 acc_we;
  logic [AddrWidth-1:0] acc_addr;
  logic [MsgWidth-1:0]  acc_wdata;

  //////////////////////////////
  // Grant
  //////////////////////////////

  // Release read always wins, the store waits a cycle
  assign read_if.gnt  = read_if.req;
  assign store_if.gnt = store_if.req && !read_if.req;

  assign access    = read_if.gnt || store_if.gnt;
  assign acc_we    = read_if.gnt ? read_if.we    : store_if.we;
  assign acc_addr  = read_if.gnt ? read_if.addr  : store_if.addr;
  assign acc_wdata = read_if.gnt ? read_if.wdata : store_if.wdata;

  //////////////////////////////
  // Single port storage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (acc_we) begin
        mem_q[acc_addr] <= acc_wdata;
      end else begin
        rdata_q <= mem_q[acc_addr];
      end
    end
  end

  assign read_if.rdata  = rdata_q;
  assign store_if.rdata = rdata_q;

endmodule

`default_nettype wire

//--- hdl/id_queue_table.sv
// Per-identifier linked lists, counters, link array and the store request path
`timescale 1ns/1ps
`default_nettype none

module id_queue_table (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic [simmem_pkg::NumIds-1:0]                        reserve_id_onehot_i,
  input  logic                                                 reserve_i,
  input  logic [simmem_pkg::AddrWidth-1:0]                     free_addr_i,
  input  simmem_pkg::msg_word_u                                data_i,
  input  logic                                                 in_valid_i,
  output logic                                                 in_ready_o,
  msg_ram_if.requester                                         store_if,
  input  logic                                                 issue_i,
  input  logic [simmem_pkg::NumIds-1:0]                        issue_id_onehot_i,
  output logic [simmem_pkg::NumIds-1:0]                        stored_o,
  output logic [simmem_pkg::NumIds-1:0][simmem_pkg::AddrWidth-1:0] out_ptr_o
);
  import simmem_pkg::*;

  // List order per identifier: out pointer, then fill pointer, then reserve tail
  logic [AddrWidth-1:0] tail_q       [NumIds];
  logic [AddrWidth-1:0] fill_q       [NumIds];
  logic [AddrWidth-1:0] out_q        [NumIds];
  logic [CntWidth-1:0]  rsv_cnt_q    [NumIds];
  logic [CntWidth-1:0]  stored_cnt_q [NumIds];

  // Next slot of each list entry
  logic [AddrWidth-1:0] link_q [Capacity];
  logic                 link_we;
  logic [AddrWidth-1:0] link_waddr;

  logic [NumIds-1:0]  reserve_here;
  logic [NumIds-1:0]  store_here;
  logic [NumIds-1:0]  issue_here;
  logic [NumIds-1:0]  has_unfilled;
  logic [NumIds-1:0]  list_empty;
  logic [IdWidth-1:0] in_id;

  //////////////////////////////
  // Store request
  //////////////////////////////

  assign in_id = data_i.fields.id;

  assign store_if.req   = in_valid_i && has_unfilled[in_id];
  assign store_if.we    = 1'b1;
  assign store_if.addr  = fill_q[in_id];
  assign store_if.wdata = data_i.raw;
  // Grant is withheld while a release read holds the memory
  assign in_ready_o     = store_if.gnt;

  //////////////////////////////
  // Per-identifier pointers
  //////////////////////////////

  for (genvar i = 0; i < NumIds; i++) begin : gen_id
    logic [AddrWidth-1:0] fill_d;
    logic [AddrWidth-1:0] out_d;
    logic [AddrWidth-1:0] tail_d;
    logic [CntWidth-1:0]  rsv_cnt_d;
    logic [CntWidth-1:0]  stored_cnt_d;

    assign has_unfilled[i] = rsv_cnt_q[i] != '0;
    assign list_empty[i]   = !has_unfilled[i] && stored_cnt_q[i] == '0;
    assign reserve_here[i] = reserve_i && reserve_id_onehot_i[i];
    assign store_here[i]   = store_if.gnt && in_id == IdWidth'(i);
    assign issue_here[i]   = issue_i && issue_id_onehot_i[i];

    assign stored_o[i]  = stored_cnt_q[i] != '0;
    assign out_ptr_o[i] = out_q[i];

    // Link at the tail is written this same edge, so forward the new slot
    always_comb begin
      fill_d = fill_q[i];
      if (store_here[i]) begin
        if (reserve_here[i] && fill_q[i] == tail_q[i]) begin
          fill_d = free_addr_i;
        end else begin
          fill_d = link_q[fill_q[i]];
        end
      end else if (reserve_here[i] && !has_unfilled[i]) begin
        fill_d = free_addr_i;
      end
    end

    always_comb begin
      out_d = out_q[i];
      if (issue_here[i]) begin
        if (reserve_here[i] && out_q[i] == tail_q[i]) begin
          out_d = free_addr_i;
        end else begin
          out_d = link_q[out_q[i]];
        end
      end else if (reserve_here[i] && list_empty[i]) begin
        out_d = free_addr_i;
      end
    end

    assign tail_d       = reserve_here[i] ? free_addr_i : tail_q[i];
    assign rsv_cnt_d    = rsv_cnt_q[i] + CntWidth'(reserve_here[i]) - CntWidth'(store_here[i]);
    assign stored_cnt_d = stored_cnt_q[i] + CntWidth'(store_here[i]) - CntWidth'(issue_here[i]);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        tail_q[i]       <= '0;
        fill_q[i]       <= '0;
        out_q[i]        <= '0;
        rsv_cnt_q[i]    <= '0;
        stored_cnt_q[i] <= '0;
      end else begin
        tail_q[i]       <= tail_d;
        fill_q[i]       <= fill_d;
        out_q[i]        <= out_d;
        rsv_cnt_q[i]    <= rsv_cnt_d;
        stored_cnt_q[i] <= stored_cnt_d;
      end
    end
  end

  //////////////////////////////
  // Link array
  //////////////////////////////

  // Only a non-empty list has a live tail to link from
  always_comb begin
    link_we    = 1'b0;
    link_waddr = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (reserve_here[i] && !list_empty[i]) begin
        link_we    = 1'b1;
        link_waddr = tail_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (link_we) begin
      link_q[link_waddr] <= free_addr_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/slot_allocator.sv
// Slot occupancy tracking with lowest free slot search
`timescale 1ns/1ps
`default_nettype none

module slot_allocator (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             alloc_i,
  input  logic [simmem_pkg::Capacity-1:0]  free_mask_i,
  output logic [simmem_pkg::AddrWidth-1:0] free_addr_o,
  output logic                             any_free_o
);
  import simmem_pkg::*;

  logic [Capacity-1:0] occupied_q;
  logic [Capacity-1:0] occupied_d;
  logic [Capacity-1:0] alloc_mask;

  //////////////////////////////
  // Lowest free slot
  //////////////////////////////

  // Scan from the top so the lowest free index is the last one kept
  always_comb begin
    free_addr_o = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!occupied_q[i]) begin
        free_addr_o = AddrWidth'(i);
      end
    end
  end

  assign any_free_o = ~&occupied_q;

  //////////////////////////////
  // Occupancy update
  //////////////////////////////

  always_comb begin
    alloc_mask = '0;
    if (alloc_i && any_free_o) begin
      alloc_mask[free_addr_o] = 1'b1;
    end
  end

  // A released slot is never the one being allocated
  assign occupied_d = (occupied_q | alloc_mask) & ~free_mask_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= occupied_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/msg_ram_if.sv
// Requester port bundle for the shared message memory
`timescale 1ns/1ps
`default_nettype none

interface msg_ram_if;
  import simmem_pkg::*;

  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [MsgWidth-1:0]  wdata;
  // Valid one cycle after a granted read
  logic [MsgWidth-1:0]  rdata;
  logic                 gnt;

  modport requester (
    output req, we, addr, wdata,
    input  rdata, gnt
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output rdata, gnt
  );

endinterface

`default_nettype wire

//--- hdl/simmem_pkg.sv
// Bank sizing constants and the message word union
`default_nettype none

package simmem_pkg;

  //////////////////////////////
  // Message format
  //////////////////////////////

  // Full message word
  localparam int MsgWidth = 32;

  // Identifier field in the low bits of the word
  localparam int IdWidth = 2;
  localparam int NumIds = 2 ** IdWidth;

  //////////////////////////////
  // Storage
  //////////////////////////////

  localparam int Capacity = 16;
  localparam int AddrWidth = $clog2(Capacity);

  // One extra bit so a full count of Capacity fits
  localparam int CntWidth = AddrWidth + 1;

  //////////////////////////////
  // Message word views
  //////////////////////////////

  // Raw view goes to memory, field view is used to decode the identifier
  typedef union packed {
    logic [MsgWidth-1:0] raw;
    struct packed {
      logic [MsgWidth-IdWidth-1:0] payload;
      logic [IdWidth-1:0]          id;
    } fields;
  } msg_word_u;

endpackage

`default_nettype wire
